// File: verilog/bank_sched_pkg.sv
`default_nettype none

package bank_sched_pkg;

  // ******************************
  // Field widths
  // ******************************
  typedef logic [11:0] burst_t; // Row tag, requests with equal tag form one burst
  typedef logic [7:0]  col_t;   // Column address inside the row
  typedef logic [3:0]  src_t;   // Source id, traces a command back to its queue

  // Occupancy of one queue, also the saturated write total
  typedef logic [3:0]  cnt_t;

  // ******************************
  // Request and command
  // ******************************
  typedef struct packed {
    burst_t burst; // Burst grouping key
    col_t   col;
    src_t   src;
  } req_t;

  // Issued command, rw uses the mode encoding below
  typedef struct packed {
    logic rw;
    req_t req;
  } cmd_t;

  // ******************************
  // Mode encoding
  // ******************************
  localparam logic MODE_READ  = 1'b1; // Reads drained first
  localparam logic MODE_WRITE = 1'b0; // Write drain until low watermark

endpackage

`default_nettype wire

// File: verilog/req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_i,  // Write strobe from the source
  input  bank_sched_pkg::req_t  req_i,
  input  logic                  pop_i,   // Remove head on this edge
  output bank_sched_pkg::req_t  head_o,  // Oldest entry, valid when not empty
  output logic                  empty_o,
  output logic                  full_o,
  output bank_sched_pkg::cnt_t  count_o
);

  import bank_sched_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  req_t             mem [FIFO_DEPTH]; // Circular storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  cnt_t             count_q;          // Entries held
  logic             do_push;
  logic             do_pop;

  // Wrap a pointer at the last slot, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push = push_i && !full_o;  // Push into a full queue is dropped
  assign do_pop  = pop_i && !empty_o;  // Pop of an empty queue is ignored

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_t'(FIFO_DEPTH));
  assign count_o = count_q;
  assign head_o  = mem[rd_ptr];        // Combinational head read

  // Storage, no reset on the data
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= req_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // Both or neither, level unchanged
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/rw_mode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rw_mode_ctrl #(
  parameter int WR_HIGH_WM = 10,
  parameter int WR_LOW_WM  = 3
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  bank_sched_pkg::cnt_t wr_count_i,     // Writes held over all write queues
  input  logic                 rd_pending_i,   // Some read queue not empty
  input  logic                 wr_pending_i,   // Some write queue not empty
  input  logic                 burst_active_i, // Scheduler inside a burst
  output logic                 mode_o
);

  import bank_sched_pkg::*;

  logic mode_q;
  logic to_write;
  logic to_read;

  // ******************************
  // Hysteresis conditions
  // ******************************

  // Enter write drain at the high mark, or when only writes wait
  assign to_write = (wr_count_i >= cnt_t'(WR_HIGH_WM)) ||
                    (!rd_pending_i && wr_pending_i);

  // Leave it once drained to the low mark with reads waiting,
  // or when nothing is left to write
  assign to_read = ((wr_count_i <= cnt_t'(WR_LOW_WM)) && rd_pending_i) ||
                   !wr_pending_i;

  // ******************************
  // Mode register
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode_q <= MODE_READ;                  // Read first out of reset
    end else if (!burst_active_i) begin     // Frozen during a burst
      if (mode_q == MODE_READ) begin
        if (to_write) mode_q <= MODE_WRITE;
      end else begin
        if (to_read) mode_q <= MODE_READ;
      end
    end
  end

  assign mode_o = mode_q;

endmodule

`default_nettype wire

// File: verilog/burst_sched.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sched #(
  parameter int RD_FIFO_NUM = 4,
  parameter int WR_FIFO_NUM = 3
) (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  ready_i, // Arbiter level
  input  logic                                                  mode_i,
  input  logic [RD_FIFO_NUM+WR_FIFO_NUM-1:0]                    empty_i, // Reads low bits
  input  bank_sched_pkg::req_t [RD_FIFO_NUM+WR_FIFO_NUM-1:0]    heads_i,
  output logic [RD_FIFO_NUM+WR_FIFO_NUM-1:0]                    pop_o,   // One-hot or zero
  output logic                                                  valid_o,
  output logic                                                  burst_active_o
);

  import bank_sched_pkg::*;

  localparam int FIFO_NUM = RD_FIFO_NUM + WR_FIFO_NUM;
  localparam int IDX_W    = (FIFO_NUM > 1) ? $clog2(FIFO_NUM) : 1;

  typedef enum logic [2:0] {
    EMPTY,
    WAITING,
    RD_BURST,
    WR_BURST,
    FINISH
  } state_t;

  state_t             state_q, state_d;
  burst_t             tag_q, tag_d;     // Tag of the burst being drained
  logic [IDX_W-1:0]   rd_ptr_q, rd_ptr_d; // Last read queue opened, global index
  logic [IDX_W-1:0]   wr_ptr_q, wr_ptr_d; // Last write queue opened
  logic [FIFO_NUM-1:0] avail;            // Non-empty queues
  logic [FIFO_NUM-1:0] hits;             // Non-empty heads matching tag_q
  logic                rd_any;
  logic                wr_any;
  logic                class_any;        // Current mode has work
  logic [IDX_W-1:0]    pick;             // Round-robin choice for a new burst

  // ******************************
  // Search functions
  // ******************************

  // First available queue after ptr, inside [base, base+num)
  function automatic logic [IDX_W-1:0] rr_pick(input logic [FIFO_NUM-1:0] av,
                                               input int base,
                                               input int num,
                                               input logic [IDX_W-1:0] ptr);
    int   loc;
    int   j;
    logic found;
    loc     = int'(ptr) - base;
    found   = 1'b0;
    rr_pick = IDX_W'(base);
    for (int k = 1; k <= FIFO_NUM; k++) begin
      j = (loc + k) % num;
      if (k <= num && !found && av[base + j]) begin
        rr_pick = IDX_W'(base + j);
        found   = 1'b1;
      end
    end
  endfunction

  // Lowest set bit inside [base, base+num)
  function automatic logic [IDX_W-1:0] low_pick(input logic [FIFO_NUM-1:0] v,
                                                input int base,
                                                input int num);
    logic found;
    found    = 1'b0;
    low_pick = IDX_W'(base);
    for (int j = 0; j < FIFO_NUM; j++) begin
      if (j >= base && j < base + num && !found && v[j]) begin
        low_pick = IDX_W'(j);
        found    = 1'b1;
      end
    end
  endfunction

  // ******************************
  // Queue status
  // ******************************
  assign avail     = ~empty_i;
  assign rd_any    = |avail[RD_FIFO_NUM-1:0];
  assign wr_any    = |avail[FIFO_NUM-1:RD_FIFO_NUM];
  assign class_any = (mode_i == MODE_READ) ? rd_any : wr_any;
  assign pick      = (mode_i == MODE_READ) ? rr_pick(avail, 0, RD_FIFO_NUM, rd_ptr_q)
                                           : rr_pick(avail, RD_FIFO_NUM, WR_FIFO_NUM, wr_ptr_q);

  always_comb begin
    for (int i = 0; i < FIFO_NUM; i++) begin
      hits[i] = avail[i] && (heads_i[i].burst == tag_q);
    end
  end

  // ******************************
  // Next state and outputs
  // ******************************
  always_comb begin
    state_d  = state_q;
    tag_d    = tag_q;
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    pop_o    = '0;
    valid_o  = 1'b0;
    case (state_q)
      EMPTY: begin
        if (class_any) state_d = WAITING;   // Valid shows on the next cycle
      end
      WAITING: begin
        valid_o = 1'b1;
        if (!class_any) begin
          state_d = EMPTY;                  // Mode switched away from our work
        end else if (ready_i) begin
          pop_o[pick] = 1'b1;               // First request of the burst
          tag_d       = heads_i[pick].burst;
          if (mode_i == MODE_READ) begin
            rd_ptr_d = pick;
            state_d  = RD_BURST;
          end else begin
            wr_ptr_d = pick;
            state_d  = WR_BURST;
          end
        end
      end
      RD_BURST: begin
        valid_o = 1'b1;
        if (|hits[RD_FIFO_NUM-1:0]) begin
          pop_o[low_pick(hits, 0, RD_FIFO_NUM)] = 1'b1;
        end else begin
          state_d = FINISH;                 // No head left with this tag
        end
      end
      WR_BURST: begin
        valid_o = 1'b1;
        if (|hits[FIFO_NUM-1:RD_FIFO_NUM]) begin
          pop_o[low_pick(hits, RD_FIFO_NUM, WR_FIFO_NUM)] = 1'b1;
        end else begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        state_d = class_any ? WAITING : EMPTY; // One idle cycle between bursts
      end
      default: state_d = EMPTY;
    endcase
  end

  assign burst_active_o = (state_q == RD_BURST) || (state_q == WR_BURST);

  // ******************************
  // Registers
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= EMPTY;
      rd_ptr_q <= IDX_W'(RD_FIFO_NUM - 1); // Next pick starts at queue 0
      wr_ptr_q <= IDX_W'(FIFO_NUM - 1);    // Next pick starts at first write queue
    end else begin
      state_q  <= state_d;
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
    end
  end

  // Tag only read inside a burst, loaded on its first pop
  always_ff @(posedge clk) begin
    tag_q <= tag_d;
  end

endmodule

`default_nettype wire

// File: verilog/cmd_issue.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_issue #(
  parameter int RD_FIFO_NUM = 4,
  parameter int WR_FIFO_NUM = 3
) (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic [RD_FIFO_NUM+WR_FIFO_NUM-1:0]                 pop_i,   // One-hot pop
  input  bank_sched_pkg::req_t [RD_FIFO_NUM+WR_FIFO_NUM-1:0] heads_i,
  output logic                                               cmd_valid_o,
  output bank_sched_pkg::cmd_t                               cmd_o
);

  import bank_sched_pkg::*;

  localparam int FIFO_NUM = RD_FIFO_NUM + WR_FIFO_NUM;

  cmd_t cmd_d;
  cmd_t cmd_q;
  logic valid_q;

  // Head mux steered by the pop bit
  always_comb begin
    cmd_d.req = '0;
    for (int i = 0; i < FIFO_NUM; i++) begin
      if (pop_i[i]) cmd_d.req = heads_i[i];
    end
    // Class from the bit position, reads sit in the low range
    cmd_d.rw = (|pop_i[RD_FIFO_NUM-1:0]) ? MODE_READ : MODE_WRITE;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= |pop_i;     // One strobe per pop cycle
    end
  end

  always_ff @(posedge clk) begin
    if (|pop_i) cmd_q <= cmd_d;   // Payload held between strobes
  end

  assign cmd_valid_o = valid_q;
  assign cmd_o       = cmd_q;

endmodule

`default_nettype wire

// File: verilog/bank_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module bank_sched_top #(
  parameter int RD_FIFO_NUM = 4,
  parameter int WR_FIFO_NUM = 3,
  parameter int FIFO_DEPTH  = 8,
  parameter int WR_HIGH_WM  = 10,
  parameter int WR_LOW_WM   = 3
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [RD_FIFO_NUM-1:0]                   rd_push_i,
  input  bank_sched_pkg::req_t [RD_FIFO_NUM-1:0]   rd_req_i,
  output logic [RD_FIFO_NUM-1:0]                   rd_full_o,
  input  logic [WR_FIFO_NUM-1:0]                   wr_push_i,
  input  bank_sched_pkg::req_t [WR_FIFO_NUM-1:0]   wr_req_i,
  output logic [WR_FIFO_NUM-1:0]                   wr_full_o,
  input  logic                                     ready_i,
  output logic                                     sched_valid_o,
  output logic                                     cmd_valid_o,
  output bank_sched_pkg::cmd_t                     cmd_o,
  output logic                                     mode_o
);

  import bank_sched_pkg::*;

  localparam int FIFO_NUM = RD_FIFO_NUM + WR_FIFO_NUM;
  localparam int SUM_W    = $bits(cnt_t) + $clog2(WR_FIFO_NUM + 1);

  logic [RD_FIFO_NUM-1:0]  rd_empty;
  logic [WR_FIFO_NUM-1:0]  wr_empty;
  req_t [RD_FIFO_NUM-1:0]  rd_head;
  req_t [WR_FIFO_NUM-1:0]  wr_head;
  cnt_t [WR_FIFO_NUM-1:0]  wr_cnt;
  logic [FIFO_NUM-1:0]     empty_all;  // Reads in the low bits
  req_t [FIFO_NUM-1:0]     heads_all;
  logic [FIFO_NUM-1:0]     pop;
  logic [SUM_W-1:0]        wr_sum;
  cnt_t                    wr_count;   // Saturated write total
  logic                    burst_active;

  // ******************************
  // Request queues
  // ******************************
  for (genvar g = 0; g < RD_FIFO_NUM; g++) begin : g_rd
    req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst_n(rst_n),
      .push_i(rd_push_i[g]), .req_i(rd_req_i[g]), .pop_i(pop[g]),
      .head_o(rd_head[g]), .empty_o(rd_empty[g]), .full_o(rd_full_o[g]),
      .count_o()                       // Read occupancy not needed for mode
    );
  end

  for (genvar g = 0; g < WR_FIFO_NUM; g++) begin : g_wr
    req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst_n(rst_n),
      .push_i(wr_push_i[g]), .req_i(wr_req_i[g]), .pop_i(pop[RD_FIFO_NUM + g]),
      .head_o(wr_head[g]), .empty_o(wr_empty[g]), .full_o(wr_full_o[g]),
      .count_o(wr_cnt[g])
    );
  end

  assign empty_all = {wr_empty, rd_empty};
  assign heads_all = {wr_head, rd_head};

  // Write total, clipped to the counter range above both watermarks
  always_comb begin
    wr_sum = '0;
    for (int i = 0; i < WR_FIFO_NUM; i++) begin
      wr_sum = wr_sum + SUM_W'(wr_cnt[i]);
    end
    wr_count = (wr_sum > SUM_W'({$bits(cnt_t){1'b1}})) ? '1 : cnt_t'(wr_sum);
  end

  // ******************************
  // Mode, scheduler, command
  // ******************************
  rw_mode_ctrl #(.WR_HIGH_WM(WR_HIGH_WM), .WR_LOW_WM(WR_LOW_WM)) u_mode (
    .clk(clk), .rst_n(rst_n),
    .wr_count_i(wr_count), .rd_pending_i(~&rd_empty), .wr_pending_i(~&wr_empty),
    .burst_active_i(burst_active), .mode_o(mode_o)
  );

  burst_sched #(.RD_FIFO_NUM(RD_FIFO_NUM), .WR_FIFO_NUM(WR_FIFO_NUM)) u_sched (
    .clk(clk), .rst_n(rst_n), .ready_i(ready_i), .mode_i(mode_o),
    .empty_i(empty_all), .heads_i(heads_all), .pop_o(pop),
    .valid_o(sched_valid_o), .burst_active_o(burst_active)
  );

  cmd_issue #(.RD_FIFO_NUM(RD_FIFO_NUM), .WR_FIFO_NUM(WR_FIFO_NUM)) u_issue (
    .clk(clk), .rst_n(rst_n), .pop_i(pop), .heads_i(heads_all),
    .cmd_valid_o(cmd_valid_o), .cmd_o(cmd_o)
  );

endmodule

`default_nettype wire

// File: testbench/bank_sched_props.sv
`timescale 1ns/1ps
`default_nettype none

module bank_sched_props #(
  parameter int FIFO_NUM = 7
) (
  input logic                clk,
  input logic                rst_n,
  input logic [FIFO_NUM-1:0] pop_i,          // Scheduler pop vector
  input logic                burst_active_i,
  input logic                mode_i,
  input logic                cmd_valid_i
);

  // ******************************
  // Pop and command timing
  // ******************************
  a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop_i))
    else $error("pop vector has more than one bit set");

  // Strobe one cycle after each pop cycle, and only then
  a_cmd_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
    (|pop_i) |=> cmd_valid_i)
    else $error("command strobe missing after a pop");
  a_no_cmd_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(|pop_i) |=> !cmd_valid_i)
    else $error("command strobe without a pop");

  // Mode frozen inside a burst
  a_mode_hold: assert property (@(posedge clk) disable iff (!rst_n)
    burst_active_i |=> $stable(mode_i))
    else $error("mode changed during a burst");

endmodule

bind bank_sched_top bank_sched_props #(.FIFO_NUM(RD_FIFO_NUM + WR_FIFO_NUM)) u_props (
  .clk(clk), .rst_n(rst_n), .pop_i(pop), .burst_active_i(burst_active),
  .mode_i(mode_o), .cmd_valid_i(cmd_valid_o)
);

`default_nettype wire

// File: testbench/bank_sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bank_sched_tb;

  import bank_sched_pkg::*;

  localparam int RD_N          = 4;
  localparam int WR_N          = 3;
  localparam int Q_N           = RD_N + WR_N;
  localparam int DEPTH         = 8;
  localparam int HIGH_WM       = 10;
  localparam int LOW_WM        = 3;
  localparam int STIM_CYCLES   = 800;   // Random push phase
  localparam int DRAIN_TIMEOUT = 2000;  // Cycles allowed to empty every queue

  logic            clk;
  logic            rst_n;
  logic            ready;
  logic [RD_N-1:0] rd_push;
  req_t [RD_N-1:0] rd_req;
  logic [RD_N-1:0] rd_full;
  logic [WR_N-1:0] wr_push;
  req_t [WR_N-1:0] wr_req;
  logic [WR_N-1:0] wr_full;
  logic            sched_valid;
  logic            cmd_valid;
  cmd_t            cmd;
  logic            mode;

  // ******************************
  // Reference model state
  // ******************************
  req_t   model_q [Q_N][$];  // One per hardware queue, reads first
  int     stamp_q [Q_N][$];  // Edge count at which each entry is written
  int     cyc = 0;           // Rising edges seen
  logic   prev_rst_n;        // Reset level at the last edge
  logic   prev_cmd_valid;    // Pop in the cycle before
  logic   prev_mode;
  logic   exp_mode;          // Watermark rule applied to model counts
  burst_t burst_tag;
  logic   burst_rw;
  int     rd_last;           // Queue that opened the last read burst
  int     wr_last;
  logic   passed;
  logic   fail_shown;

  bank_sched_top #(
    .RD_FIFO_NUM(RD_N), .WR_FIFO_NUM(WR_N), .FIFO_DEPTH(DEPTH),
    .WR_HIGH_WM(HIGH_WM), .WR_LOW_WM(LOW_WM)
  ) u_dut (
    .clk(clk), .rst_n(rst_n),
    .rd_push_i(rd_push), .rd_req_i(rd_req), .rd_full_o(rd_full),
    .wr_push_i(wr_push), .wr_req_i(wr_req), .wr_full_o(wr_full),
    .ready_i(ready), .sched_valid_o(sched_valid),
    .cmd_valid_o(cmd_valid), .cmd_o(cmd), .mode_o(mode)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_failure(input string what);
    fail_shown = 1'b1;
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // Entry already in the hardware queue during the cycle before this negedge
  function automatic bit head_ready(input int q);
    return (model_q[q].size() != 0) && (stamp_q[q][0] < cyc);
  endfunction

  function automatic int ready_count(input int lo, input int hi);
    int n;
    n = 0;
    for (int q = lo; q < hi; q++) begin
      for (int e = 0; e < stamp_q[q].size(); e++) begin
        if (stamp_q[q][e] < cyc) n++;
      end
    end
    return n;
  endfunction

  // Entries written into queue q by the last edge
  function automatic int held_count(input int q);
    int n;
    n = 0;
    for (int e = 0; e < stamp_q[q].size(); e++) begin
      if (stamp_q[q][e] <= cyc) n++;
    end
    return n;
  endfunction

  function automatic int model_total();
    int n;
    n = 0;
    for (int q = 0; q < Q_N; q++) n += model_q[q].size();
    return n;
  endfunction

  // First queue of the class after last, cyclic
  function automatic int rr_next(input logic rw, input int last);
    int base;
    int num;
    int j;
    int res;
    base = (rw == MODE_READ) ? 0 : RD_N;
    num  = (rw == MODE_READ) ? RD_N : WR_N;
    res  = -1;
    for (int k = 1; k <= num; k++) begin
      j = base + ((last - base + k) % num);
      if (res < 0 && head_ready(j)) res = j;
    end
    return res;
  endfunction

  // Lowest queue of the class whose head carries tag
  function automatic int lowest_hit(input logic rw, input burst_t tag);
    int base;
    int res;
    base = (rw == MODE_READ) ? 0 : RD_N;
    res  = -1;
    for (int j = base; j < base + ((rw == MODE_READ) ? RD_N : WR_N); j++) begin
      if (res < 0 && head_ready(j) && model_q[j][0].burst == tag) res = j;
    end
    return res;
  endfunction

  // Hysteresis: high mark or writes only enter write drain
  function automatic logic next_mode(input logic cur);
    int wr_n;
    bit rd_any;
    wr_n   = ready_count(RD_N, Q_N);
    rd_any = (ready_count(0, RD_N) != 0);
    if (cur == MODE_READ) begin
      return (wr_n >= HIGH_WM || (!rd_any && wr_n != 0)) ? MODE_WRITE : MODE_READ;
    end
    return ((wr_n <= LOW_WM && rd_any) || wr_n == 0) ? MODE_READ : MODE_WRITE;
  endfunction

  // One cycle of stimulus, 2 ns after the edge
  task automatic drive_cycle(input bit allow_push);
    req_t r;
    bit   go;
    @(posedge clk);
    #2;
    ready = allow_push ? (($urandom % 3) != 0) : 1'b1;
    for (int i = 0; i < Q_N; i++) begin
      go = allow_push && (model_q[i].size() < DEPTH) &&
           (($urandom % 100) < ((i < RD_N) ? 20 : 30));
      r.burst = burst_t'(12'h100 + ($urandom % 3)); // Few tags, so hits happen
      r.col   = col_t'($urandom);
      r.src   = src_t'(i);                          // Queue index as source id
      if (i < RD_N) begin
        rd_push[i] = go;
        rd_req[i]  = r;
      end else begin
        wr_push[i - RD_N] = go;
        wr_req[i - RD_N]  = r;
      end
      if (go) begin
        model_q[i].push_back(r);
        stamp_q[i].push_back(cyc + 1);  // Written on the next edge
      end
    end
  endtask

  // ******************************
  // Checks at the falling edge
  // ******************************
  always @(negedge clk) begin : monitor
    int q;
    int want;
    logic [Q_N-1:0] full_exp;
    if (!prev_rst_n) begin
      exp_mode = MODE_READ;
      assert (!sched_valid && !cmd_valid)
        else report_failure("valid level high out of reset");
    end else begin
      if (!prev_cmd_valid) exp_mode = next_mode(exp_mode);  // Held inside a burst
      if (ready_count(0, Q_N) == 0) begin
        assert (!sched_valid) else report_failure("scheduler valid with all queues empty");
      end
      if (cmd_valid) begin
        q = int'(cmd.req.src);
        assert (q < Q_N && head_ready(q))
          else report_failure("command issued from a queue with nothing pending");
        assert (cmd.req == model_q[q][0])
          else report_failure($sformatf("mismatch cmd_o.req: got %h expected %h",
                                        cmd.req, model_q[q][0]));
        assert (cmd.rw == ((q < RD_N) ? MODE_READ : MODE_WRITE))
          else report_failure($sformatf("mismatch cmd_o.rw: got %h expected %h", cmd.rw,
                                        (q < RD_N) ? MODE_READ : MODE_WRITE));
        if (prev_cmd_valid) begin
          // Same burst, lowest matching head
          want = lowest_hit(burst_rw, burst_tag);
          assert (cmd.req.burst == burst_tag && cmd.rw == burst_rw)
            else report_failure($sformatf("mismatch cmd_o.req.burst: got %h expected %h",
                                          cmd.req.burst, burst_tag));
          assert (q == want)
            else report_failure($sformatf("mismatch cmd_o.req.src: got %h expected %h", q, want));
        end else begin
          // First of a burst, class from the mode, queue by round robin
          want = rr_next(cmd.rw, (cmd.rw == MODE_READ) ? rd_last : wr_last);
          assert (cmd.rw == prev_mode)
            else report_failure($sformatf("mismatch cmd_o.rw: got %h expected %h",
                                          cmd.rw, prev_mode));
          assert (q == want)
            else report_failure($sformatf("mismatch cmd_o.req.src: got %h expected %h", q, want));
          burst_tag = cmd.req.burst;
          burst_rw  = cmd.rw;
          if (cmd.rw == MODE_READ) rd_last = q;
          else wr_last = q;
        end
        void'(model_q[q].pop_front());
        void'(stamp_q[q].pop_front());
      end else if (prev_cmd_valid) begin
        assert (lowest_hit(burst_rw, burst_tag) < 0)
          else report_failure("burst ended while a head of its class still carried the tag");
      end
    end
    for (int i = 0; i < Q_N; i++) begin
      full_exp[i] = (held_count(i) == DEPTH);  // Full once DEPTH entries are held
    end
    assert ({wr_full, rd_full} == full_exp)
      else report_failure($sformatf("mismatch {wr_full_o, rd_full_o}: got %h expected %h",
                                    {wr_full, rd_full}, full_exp));
    assert (mode == exp_mode)
      else report_failure($sformatf("mismatch mode_o: got %h expected %h", mode, exp_mode));
    prev_cmd_valid = cmd_valid;
    prev_mode      = mode;
    prev_rst_n     = rst_n;
  end

  // ******************************
  // Main sequence
  // ******************************
  initial begin : main
    int guard;
    void'($urandom(32'h2e5a));
    rst_n   = 1'b0;
    ready   = 1'b0;
    rd_push = '0;
    rd_req  = '0;
    wr_push = '0;
    wr_req  = '0;
    prev_rst_n     = 1'b0;
    prev_cmd_valid = 1'b0;
    prev_mode      = MODE_READ;
    exp_mode       = MODE_READ;
    burst_tag      = '0;
    burst_rw       = MODE_READ;
    rd_last        = RD_N - 1;  // Pointers start at the last queue of each class
    wr_last        = Q_N - 1;
    passed         = 1'b0;
    fail_shown     = 1'b0;
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
    repeat (8) drive_cycle(1'b0);        // Idle, nothing may issue
    repeat (STIM_CYCLES) drive_cycle(1'b1);
    guard = 0;
    while (model_total() != 0 && guard < DRAIN_TIMEOUT) begin
      drive_cycle(1'b0);                 // Ready held high, no pushes
      guard++;
    end
    if (model_total() != 0) report_failure("timeout waiting for the queues to drain");
    repeat (8) drive_cycle(1'b0);        // Any extra command fails the order check
    passed = 1'b1;
    $display("TESTS PASSED");
    $finish;
  end

  final begin
    if (!passed && !fail_shown) begin
      $display("TESTS FAILED");          // Stopped early by a bound property
    end
  end

endmodule

`default_nettype wire

// File: project.f
verilog/bank_sched_pkg.sv
verilog/req_fifo.sv
verilog/rw_mode_ctrl.sv
verilog/burst_sched.sv
verilog/cmd_issue.sv
verilog/bank_sched_top.sv
testbench/bank_sched_props.sv
testbench/bank_sched_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bank_sched_tb -f project.f

output=$(./obj_dir/Vbank_sched_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
